//--- logic/rob_pkg.sv
/*
  Reorder buffer parameters
  Slot count, tag width and data width shared by the buffer,
  the execution lanes and the top level
*/

package rob_pkg;

  // Number of buffer slots, also the bound on in-flight work
  localparam int ROB_DEPTH = 8;

  // Slot tag width
  // Ring pointers wrap on their own because depth is a power of two
  localparam int INDEX_WIDTH = $clog2(ROB_DEPTH);

  // Operand and result width
  localparam int DATA_WIDTH = 16;

endpackage

//--- logic/op_pkg.sv
/*
  Operation and configuration definitions
  Opcodes, multiply latency range, register addresses and the
  configuration write word with its two decodings
*/

package op_pkg;

  // Opcodes
  localparam int         OP_WIDTH = 2;
  localparam logic [1:0] OP_ADD   = 2'd0;
  localparam logic [1:0] OP_SUB   = 2'd1;
  localparam logic [1:0] OP_XOR   = 2'd2;
  localparam logic [1:0] OP_MUL   = 2'd3;

  // Multiply latency range, in cycles
  localparam int MUL_LAT_MIN   = 1;
  localparam int MUL_LAT_MAX   = 7;
  localparam int MUL_LAT_RESET = 3;
  localparam int LAT_WIDTH     = $clog2(MUL_LAT_MAX + 1);

  // Error counters, saturating
  localparam int COUNT_WIDTH = 8;

  // Register addresses
  localparam int         CFG_ADDR_WIDTH   = 2;
  localparam logic [1:0] CFG_ADDR_LATENCY = 2'd0;
  localparam logic [1:0] CFG_ADDR_ERRORS  = 2'd1;
  localparam logic [1:0] CFG_ADDR_CLEAR   = 2'd2;

  // Write word, meaning depends on the target address
  typedef union packed {
    struct packed {
      logic [rob_pkg::DATA_WIDTH-LAT_WIDTH-1:0] pad;
      logic [LAT_WIDTH-1:0]                     value;
    } latency;
    struct packed {
      logic [rob_pkg::DATA_WIDTH-3:0] pad;
      logic                           reserve;
      logic                           read;
    } clear;
  } cfg_word_t;

endpackage

//--- logic/reorder_buffer.sv
/*
  Reorder buffer
  Slots are reserved in ring order at issue, written by tag in any
  order, and read back in reservation order once their data is in
*/

`timescale 1ns/1ps

module reorder_buffer
  import rob_pkg::*;
(
  input  logic                   clock,
  input  logic                   resetn,
  // Reservation
  input  logic                   issue,
  output logic                   accepted,
  output logic [INDEX_WIDTH-1:0] reserve_index,
  output logic                   reserve_error,
  // Tagged write
  input  logic                   write_enable,
  input  logic [INDEX_WIDTH-1:0] write_index,
  input  logic [DATA_WIDTH-1:0]  write_data,
  // In-order read
  input  logic                   read,
  output logic                   read_valid,
  output logic [DATA_WIDTH-1:0]  read_data,
  output logic                   read_error,
  // Status
  output logic                   full,
  output logic                   empty
);

  // Result storage
  logic [DATA_WIDTH-1:0] data [ROB_DEPTH];

  // Per-slot state
  logic [ROB_DEPTH-1:0] reserved;
  logic [ROB_DEPTH-1:0] reserved_next;
  logic [ROB_DEPTH-1:0] valid;
  logic [ROB_DEPTH-1:0] valid_next;

  // Ring pointers
  logic [INDEX_WIDTH-1:0] reserve_pointer;
  logic [INDEX_WIDTH-1:0] read_pointer;

  // Read that actually frees a slot
  logic read_ok;

  // Acceptance decided here only
  assign accepted      = issue && !full;
  assign reserve_error = issue && full;
  assign reserve_index = reserve_pointer;

  // Oldest slot drives the output
  assign read_valid = valid[read_pointer];
  assign read_data  = data[read_pointer];
  assign read_ok    = read && read_valid;
  assign read_error = read && !read_valid;

  // Next-state slot flags
  always_comb begin
    reserved_next = reserved;
    valid_next    = valid;
    // Reserve at the ring pointer
    if (accepted) begin
      reserved_next[reserve_pointer] = 1'b1;
    end
    // Result lands by tag
    if (write_enable) begin
      valid_next[write_index] = 1'b1;
    end
    // Oldest slot retires
    // Never the slot being reserved, since that one was free
    if (read_ok) begin
      reserved_next[read_pointer] = 1'b0;
      valid_next[read_pointer]    = 1'b0;
    end
  end

  // Control state
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      reserved        <= '0;
      valid           <= '0;
      reserve_pointer <= '0;
      read_pointer    <= '0;
      full            <= 1'b0;
      empty           <= 1'b1;
    end else begin
      reserved <= reserved_next;
      valid    <= valid_next;
      if (accepted) begin
        reserve_pointer <= reserve_pointer + 1'b1;
      end
      if (read_ok) begin
        read_pointer <= read_pointer + 1'b1;
      end
      // Flags follow the next-state reservation map
      full  <= &reserved_next;
      empty <= ~|reserved_next;
    end
  end

  // Payload
  always_ff @(posedge clock) begin
    if (write_enable) begin
      data[write_index] <= write_data;
    end
  end

endmodule

//--- logic/exec_lanes.sv
/*
  Execution lanes
  Fast lane for add, subtract and xor feeding a tagged result queue,
  slow lane for multiply with a per-item countdown, merged onto the
  single buffer write port with the slow lane first
*/

`timescale 1ns/1ps

module exec_lanes
  import rob_pkg::*;
  import op_pkg::*;
(
  input  logic                   clock,
  input  logic                   resetn,
  // Accepted issue
  input  logic                   accepted,
  input  logic [INDEX_WIDTH-1:0] accepted_index,
  input  logic [OP_WIDTH-1:0]    op,
  input  logic [DATA_WIDTH-1:0]  a,
  input  logic [DATA_WIDTH-1:0]  b,
  // Multiply latency from the register block
  input  logic [LAT_WIDTH-1:0]   mul_latency,
  // Buffer write port
  output logic                   write_enable,
  output logic [INDEX_WIDTH-1:0] write_index,
  output logic [DATA_WIDTH-1:0]  write_data
);

  // Fast lane
  logic                   fast_push;
  logic                   fast_pop;
  logic [DATA_WIDTH-1:0]  fast_result;
  logic [INDEX_WIDTH-1:0] queue_tag  [ROB_DEPTH];
  logic [DATA_WIDTH-1:0]  queue_data [ROB_DEPTH];
  logic [INDEX_WIDTH-1:0] queue_write_pointer;
  logic [INDEX_WIDTH-1:0] queue_read_pointer;
  logic [INDEX_WIDTH:0]   queue_count;

  // Slow lane, one slot per buffer tag
  // Tags are unique in flight, so no free-slot search
  logic                   mul_push;
  logic [LAT_WIDTH-1:0]   mul_count [ROB_DEPTH];
  logic [DATA_WIDTH-1:0]  mul_data  [ROB_DEPTH];
  logic                   slow_done;
  logic [INDEX_WIDTH-1:0] slow_pick;

  assign mul_push  = accepted && (op == OP_MUL);
  assign fast_push = accepted && (op != OP_MUL);

  // Fast arithmetic
  always_comb begin
    case (op)
      OP_ADD:  fast_result = a + b;
      OP_SUB:  fast_result = a - b;
      OP_XOR:  fast_result = a ^ b;
      default: fast_result = '0;
    endcase
  end

  // Finished multiply, lowest tag wins on a collision
  // Collisions only follow a latency decrease
  always_comb begin
    slow_done = 1'b0;
    slow_pick = '0;
    for (int i = ROB_DEPTH - 1; i >= 0; i--) begin
      if (mul_count[i] == LAT_WIDTH'(1)) begin
        slow_done = 1'b1;
        slow_pick = INDEX_WIDTH'(i);
      end
    end
  end

  // Port arbitration
  assign fast_pop     = !slow_done && (queue_count != '0);
  assign write_enable = slow_done || (queue_count != '0);
  assign write_index  = slow_done ? slow_pick : queue_tag[queue_read_pointer];
  assign write_data   = slow_done ? mul_data[slow_pick] : queue_data[queue_read_pointer];

  // Queue pointers and countdowns
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      queue_write_pointer <= '0;
      queue_read_pointer  <= '0;
      queue_count         <= '0;
      for (int i = 0; i < ROB_DEPTH; i++) begin
        mul_count[i] <= '0;
      end
    end else begin
      // Depth bound by the buffer, cannot overflow
      if (fast_push) begin
        queue_write_pointer <= queue_write_pointer + 1'b1;
      end
      if (fast_pop) begin
        queue_read_pointer <= queue_read_pointer + 1'b1;
      end
      if (fast_push && !fast_pop) begin
        queue_count <= queue_count + 1'b1;
      end else if (!fast_push && fast_pop) begin
        queue_count <= queue_count - 1'b1;
      end
      // Count down, a finished item holds until it gets the port
      for (int i = 0; i < ROB_DEPTH; i++) begin
        if (mul_count[i] > LAT_WIDTH'(1)) begin
          mul_count[i] <= mul_count[i] - 1'b1;
        end else if (mul_count[i] == LAT_WIDTH'(1) && slow_pick == INDEX_WIDTH'(i)) begin
          mul_count[i] <= '0;
        end
      end
      // Latency latched per item here
      if (mul_push) begin
        mul_count[accepted_index] <= mul_latency;
      end
    end
  end

  // Payload
  always_ff @(posedge clock) begin
    if (fast_push) begin
      queue_tag[queue_write_pointer]  <= accepted_index;
      queue_data[queue_write_pointer] <= fast_result;
    end
    // Low half of the product
    if (mul_push) begin
      mul_data[accepted_index] <= a * b;
    end
  end

endmodule

//--- logic/unit_config.sv
/*
  Configuration register block
  Holds the multiply latency and two saturating protocol error
  counters, written and read through a plain register port
*/

`timescale 1ns/1ps

module unit_config
  import rob_pkg::*;
  import op_pkg::*;
(
  input  logic                      clock,
  input  logic                      resetn,
  // Register port
  input  logic                      cfg_write,
  input  logic [CFG_ADDR_WIDTH-1:0] cfg_address,
  input  logic [DATA_WIDTH-1:0]     cfg_wdata,
  output logic [DATA_WIDTH-1:0]     cfg_rdata,
  // Error pulses from the buffer
  input  logic                      reserve_error,
  input  logic                      read_error,
  // To the slow lane
  output logic [LAT_WIDTH-1:0]      mul_latency
);

  cfg_word_t              word;
  logic                   latency_write;
  logic                   latency_legal;
  logic                   clear_write;
  logic [COUNT_WIDTH-1:0] reserve_count;
  logic [COUNT_WIDTH-1:0] read_count;

  assign word          = cfg_wdata;
  assign latency_write = cfg_write && (cfg_address == CFG_ADDR_LATENCY);
  assign clear_write   = cfg_write && (cfg_address == CFG_ADDR_CLEAR);

  // Zero padding keeps the value at or below the maximum
  assign latency_legal = (word.latency.pad == '0) &&
                         (word.latency.value >= LAT_WIDTH'(MUL_LAT_MIN));

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      mul_latency   <= LAT_WIDTH'(MUL_LAT_RESET);
      reserve_count <= '0;
      read_count    <= '0;
    end else begin
      // Illegal values are dropped
      if (latency_write && latency_legal) begin
        mul_latency <= word.latency.value;
      end
      // Clear beats a same-cycle error
      if (clear_write && word.clear.reserve) begin
        reserve_count <= '0;
      end else if (reserve_error && reserve_count != '1) begin
        reserve_count <= reserve_count + 1'b1;
      end
      if (clear_write && word.clear.read) begin
        read_count <= '0;
      end else if (read_error && read_count != '1) begin
        read_count <= read_count + 1'b1;
      end
    end
  end

  // Combinational read-back
  always_comb begin
    case (cfg_address)
      CFG_ADDR_LATENCY: cfg_rdata = DATA_WIDTH'(mul_latency);
      CFG_ADDR_ERRORS:  cfg_rdata = {reserve_count, read_count};
      default:          cfg_rdata = '0;
    endcase
  end

endmodule

//--- logic/completion_unit.sv
/*
  Completion unit top level
  Reorder buffer, execution lanes and configuration block
*/

`timescale 1ns/1ps

module completion_unit
  import rob_pkg::*;
  import op_pkg::*;
(
  input  logic                      clock,
  input  logic                      resetn,
  // Issue
  input  logic                      issue,
  input  logic [OP_WIDTH-1:0]       issue_op,
  input  logic [DATA_WIDTH-1:0]     issue_a,
  input  logic [DATA_WIDTH-1:0]     issue_b,
  output logic                      issue_accepted,
  output logic [INDEX_WIDTH-1:0]    issue_index,
  // Read
  input  logic                      read,
  output logic                      read_valid,
  output logic [DATA_WIDTH-1:0]     read_data,
  // Configuration
  input  logic                      cfg_write,
  input  logic [CFG_ADDR_WIDTH-1:0] cfg_address,
  input  logic [DATA_WIDTH-1:0]     cfg_wdata,
  output logic [DATA_WIDTH-1:0]     cfg_rdata,
  // Status
  output logic                      full,
  output logic                      empty
);

  // Lane results into the buffer
  logic                   write_enable;
  logic [INDEX_WIDTH-1:0] write_index;
  logic [DATA_WIDTH-1:0]  write_data;

  // Error pulses and latency setting
  logic                   reserve_error;
  logic                   read_error;
  logic [LAT_WIDTH-1:0]   mul_latency;

  reorder_buffer reorder_buffer_inst (
    .clock         (clock),
    .resetn        (resetn),
    .issue         (issue),
    .accepted      (issue_accepted),
    .reserve_index (issue_index),
    .reserve_error (reserve_error),
    .write_enable  (write_enable),
    .write_index   (write_index),
    .write_data    (write_data),
    .read          (read),
    .read_valid    (read_valid),
    .read_data     (read_data),
    .read_error    (read_error),
    .full          (full),
    .empty         (empty)
  );

  // Lanes only see issues the buffer accepted
  exec_lanes exec_lanes_inst (
    .clock          (clock),
    .resetn         (resetn),
    .accepted       (issue_accepted),
    .accepted_index (issue_index),
    .op             (issue_op),
    .a              (issue_a),
    .b              (issue_b),
    .mul_latency    (mul_latency),
    .write_enable   (write_enable),
    .write_index    (write_index),
    .write_data     (write_data)
  );

  unit_config unit_config_inst (
    .clock         (clock),
    .resetn        (resetn),
    .cfg_write     (cfg_write),
    .cfg_address   (cfg_address),
    .cfg_wdata     (cfg_wdata),
    .cfg_rdata     (cfg_rdata),
    .reserve_error (reserve_error),
    .read_error    (read_error),
    .mul_latency   (mul_latency)
  );

endmodule

//--- test/tb_props.sv
/*
  Reorder buffer assertions
  Bound into the buffer to watch the status flags, acceptance
  and the tagged write port against the reservation map
*/

`timescale 1ns/1ps

module tb_props
  import rob_pkg::*;
(
  input logic                   clock,
  input logic                   resetn,
  input logic                   accepted,
  input logic [INDEX_WIDTH-1:0] reserve_index,
  input logic                   full,
  input logic                   empty,
  input logic                   write_enable,
  input logic [INDEX_WIDTH-1:0] write_index,
  input logic [ROB_DEPTH-1:0]   reserved
);

  // Per-rule failure tallies
  int flag_failures   = 0;
  int accept_failures = 0;
  int write_failures  = 0;
  int failures;

  assign failures = flag_failures + accept_failures + write_failures;

  // Flags track the reservation map, so never full and empty at once
  flags_match_map: assert property (@(posedge clock) disable iff (!resetn)
    (full == &reserved) && (empty == ~|reserved))
    else begin
      $error("full or empty disagrees with the reservation map");
      flag_failures++;
    end

  // Acceptance only into a free slot, never while full
  no_accept_when_full: assert property (@(posedge clock) disable iff (!resetn)
    accepted |-> !reserved[reserve_index])
    else begin
      $error("issue accepted into slot %0d which is already reserved", reserve_index);
      accept_failures++;
    end

  // Results only land in reserved slots
  write_to_reserved: assert property (@(posedge clock) disable iff (!resetn)
    write_enable |-> reserved[write_index])
    else begin
      $error("result written to slot %0d which is not reserved", write_index);
      write_failures++;
    end

endmodule

//--- test/tb_checker.sv
/*
  Completion unit checker
  Models issue order, slot occupancy and the register block,
  and compares the DUT outputs against that model every cycle
*/

`timescale 1ns/1ps

module tb_checker
  import rob_pkg::*;
  import op_pkg::*;
(
  input  logic                      clock,
  input  logic                      resetn,
  input  logic                      issue,
  input  logic [OP_WIDTH-1:0]       issue_op,
  input  logic [DATA_WIDTH-1:0]     issue_a,
  input  logic [DATA_WIDTH-1:0]     issue_b,
  input  logic                      issue_accepted,
  input  logic [INDEX_WIDTH-1:0]    issue_index,
  input  logic                      read,
  input  logic                      read_valid,
  input  logic [DATA_WIDTH-1:0]     read_data,
  input  logic                      cfg_write,
  input  logic [CFG_ADDR_WIDTH-1:0] cfg_address,
  input  logic [DATA_WIDTH-1:0]     cfg_wdata,
  input  logic [DATA_WIDTH-1:0]     cfg_rdata,
  input  logic                      full,
  input  logic                      empty,
  output int                        errors
);

  int error_count = 0;

  // Model state
  int                     occupancy;
  logic [INDEX_WIDTH-1:0] next_tag;
  logic [DATA_WIDTH-1:0]  expected_q [$];
  logic [LAT_WIDTH-1:0]   model_latency;
  logic [COUNT_WIDTH-1:0] model_reserve_count;
  logic [COUNT_WIDTH-1:0] model_read_count;

  // Per-cycle scratch
  logic                   expect_accept;
  logic                   read_ok;
  logic                   reserve_miss;
  logic [DATA_WIDTH-1:0]  expected;
  cfg_word_t              word;

  assign errors = error_count;

  // Reference arithmetic, product cut to the low half
  function automatic logic [DATA_WIDTH-1:0] expected_result(
    input logic [OP_WIDTH-1:0]   op,
    input logic [DATA_WIDTH-1:0] a,
    input logic [DATA_WIDTH-1:0] b
  );
    logic [2*DATA_WIDTH-1:0] product;
    logic [DATA_WIDTH-1:0]   result;
    product = {{DATA_WIDTH{1'b0}}, a} * {{DATA_WIDTH{1'b0}}, b};
    case (op)
      OP_ADD:  result = a + b;
      OP_SUB:  result = a - b;
      OP_XOR:  result = a ^ b;
      default: result = product[DATA_WIDTH-1:0];
    endcase
    return result;
  endfunction

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, want);
      error_count++;
    end
  endtask

  task automatic check_word(
    input string                 name,
    input logic [DATA_WIDTH-1:0] got,
    input logic [DATA_WIDTH-1:0] want
  );
    if (got !== want) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
      error_count++;
    end
  endtask

  // Compare on pre-edge values, then advance the model
  always @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      occupancy           = 0;
      next_tag            = '0;
      expected_q.delete();
      model_latency       = LAT_WIDTH'(MUL_LAT_RESET);
      model_reserve_count = '0;
      model_read_count    = '0;
    end else begin
      expect_accept = issue && (occupancy != ROB_DEPTH);
      reserve_miss  = issue && (occupancy == ROB_DEPTH);
      read_ok       = read && read_valid;

      // Acceptance and tag in ring order
      check_flag("issue_accepted", issue_accepted, expect_accept);
      if (expect_accept) begin
        check_word("issue_index", DATA_WIDTH'(issue_index), DATA_WIDTH'(next_tag));
      end

      // Flags against occupancy
      check_flag("full", full, occupancy == ROB_DEPTH);
      check_flag("empty", empty, occupancy == 0);
      if (occupancy == 0) begin
        check_flag("read_valid", read_valid, 1'b0);
      end

      // In-order results
      if (read_ok) begin
        if (expected_q.size() == 0) begin
          $display("Read at %0t returned data while no result was outstanding", $time);
          error_count++;
        end else begin
          expected = expected_q.pop_front();
          check_word("read_data", read_data, expected);
        end
      end

      // Register read-back
      if (cfg_address == CFG_ADDR_LATENCY) begin
        check_word("latency read-back", cfg_rdata, DATA_WIDTH'(model_latency));
      end else if (cfg_address == CFG_ADDR_ERRORS) begin
        check_word("error counters", cfg_rdata, {model_reserve_count, model_read_count});
      end

      // Model update
      if (expect_accept) begin
        expected_q.push_back(expected_result(issue_op, issue_a, issue_b));
        next_tag  = next_tag + 1'b1;
        occupancy = occupancy + 1;
      end
      if (read_ok) begin
        occupancy = occupancy - 1;
      end

      // Only one to seven is a legal latency
      if (cfg_write && cfg_address == CFG_ADDR_LATENCY &&
          cfg_wdata >= DATA_WIDTH'(MUL_LAT_MIN) && cfg_wdata <= DATA_WIDTH'(MUL_LAT_MAX)) begin
        model_latency = LAT_WIDTH'(cfg_wdata);
      end

      // Clear wins over a same-cycle error
      word = cfg_wdata;
      if (cfg_write && cfg_address == CFG_ADDR_CLEAR && word.clear.reserve) begin
        model_reserve_count = '0;
      end else if (reserve_miss && model_reserve_count != '1) begin
        model_reserve_count = model_reserve_count + 1'b1;
      end
      if (cfg_write && cfg_address == CFG_ADDR_CLEAR && word.clear.read) begin
        model_read_count = '0;
      end else if (read && !read_valid && model_read_count != '1) begin
        model_read_count = model_read_count + 1'b1;
      end
    end
  end

endmodule

//--- test/tb_top.sv
/*
  Completion unit testbench
  Clock, reset, random and directed stimulus, the DUT,
  the checker, the bound buffer assertions and the final report
*/

`timescale 1ns/1ps

module tb_top
  import rob_pkg::*;
  import op_pkg::*;
();

  logic                      clock;
  logic                      resetn;
  logic                      issue;
  logic [OP_WIDTH-1:0]       issue_op;
  logic [DATA_WIDTH-1:0]     issue_a;
  logic [DATA_WIDTH-1:0]     issue_b;
  logic                      issue_accepted;
  logic [INDEX_WIDTH-1:0]    issue_index;
  logic                      read;
  logic                      read_valid;
  logic [DATA_WIDTH-1:0]     read_data;
  logic                      cfg_write;
  logic [CFG_ADDR_WIDTH-1:0] cfg_address;
  logic [DATA_WIDTH-1:0]     cfg_wdata;
  logic [DATA_WIDTH-1:0]     cfg_rdata;
  logic                      full;
  logic                      empty;

  int          check_errors;
  int          timeouts;
  logic [31:0] lfsr;

  completion_unit completion_unit_inst (
    .clock          (clock),
    .resetn         (resetn),
    .issue          (issue),
    .issue_op       (issue_op),
    .issue_a        (issue_a),
    .issue_b        (issue_b),
    .issue_accepted (issue_accepted),
    .issue_index    (issue_index),
    .read           (read),
    .read_valid     (read_valid),
    .read_data      (read_data),
    .cfg_write      (cfg_write),
    .cfg_address    (cfg_address),
    .cfg_wdata      (cfg_wdata),
    .cfg_rdata      (cfg_rdata),
    .full           (full),
    .empty          (empty)
  );

  tb_checker tb_checker_inst (
    .clock          (clock),
    .resetn         (resetn),
    .issue          (issue),
    .issue_op       (issue_op),
    .issue_a        (issue_a),
    .issue_b        (issue_b),
    .issue_accepted (issue_accepted),
    .issue_index    (issue_index),
    .read           (read),
    .read_valid     (read_valid),
    .read_data      (read_data),
    .cfg_write      (cfg_write),
    .cfg_address    (cfg_address),
    .cfg_wdata      (cfg_wdata),
    .cfg_rdata      (cfg_rdata),
    .full           (full),
    .empty          (empty),
    .errors         (check_errors)
  );

  // Assertions ride inside every buffer instance
  bind reorder_buffer tb_props tb_props_inst (
    .clock         (clock),
    .resetn        (resetn),
    .accepted      (accepted),
    .reserve_index (reserve_index),
    .full          (full),
    .empty         (empty),
    .write_enable  (write_enable),
    .write_index   (write_index),
    .reserved      (reserved)
  );

  // 20 ns period
  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] take_bits(input int count);
    logic [31:0] bits;
    logic        feedback;
    int          i;
    bits = '0;
    for (i = 0; i < count; i++) begin
      feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr     = {lfsr[30:0], feedback};
      bits     = {bits[30:0], feedback};
    end
    return bits;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] make_clear_word(
    input logic reserve_bit,
    input logic read_bit
  );
    cfg_word_t word;
    word               = '0;
    word.clear.reserve = reserve_bit;
    word.clear.read    = read_bit;
    return word;
  endfunction

  // One clock of stimulus, applied just after the edge
  task automatic drive_cycle(
    input logic                      do_issue,
    input logic [OP_WIDTH-1:0]       op,
    input logic [DATA_WIDTH-1:0]     a,
    input logic [DATA_WIDTH-1:0]     b,
    input logic                      do_read,
    input logic                      do_write,
    input logic [CFG_ADDR_WIDTH-1:0] address,
    input logic [DATA_WIDTH-1:0]     wdata
  );
    @(posedge clock);
    issue       <= do_issue;
    issue_op    <= op;
    issue_a     <= a;
    issue_b     <= b;
    read        <= do_read;
    cfg_write   <= do_write;
    cfg_address <= address;
    cfg_wdata   <= wdata;
  endtask

  task automatic idle_cycle(input logic [CFG_ADDR_WIDTH-1:0] address);
    drive_cycle(1'b0, OP_ADD, '0, '0, 1'b0, 1'b0, address, '0);
  endtask

  task automatic issue_cycle(input logic [OP_WIDTH-1:0] op);
    drive_cycle(1'b1, op, DATA_WIDTH'(take_bits(DATA_WIDTH)), DATA_WIDTH'(take_bits(DATA_WIDTH)),
                1'b0, 1'b0, CFG_ADDR_ERRORS, '0);
  endtask

  task automatic write_cycle(
    input logic [CFG_ADDR_WIDTH-1:0] address,
    input logic [DATA_WIDTH-1:0]     wdata
  );
    drive_cycle(1'b0, OP_ADD, '0, '0, 1'b0, 1'b1, address, wdata);
  endtask

  // Random opcodes, reads and register writes, some of them illegal
  task automatic run_random_mix(input int cycles);
    int                        n;
    logic                      do_issue;
    logic                      do_read;
    logic                      do_write;
    logic                      pick;
    logic [OP_WIDTH-1:0]       op;
    logic [DATA_WIDTH-1:0]     a;
    logic [DATA_WIDTH-1:0]     b;
    logic [DATA_WIDTH-1:0]     wdata;
    logic [CFG_ADDR_WIDTH-1:0] address;
    for (n = 0; n < cycles; n++) begin
      do_issue = 1'(take_bits(1));
      op       = OP_WIDTH'(take_bits(OP_WIDTH));
      a        = DATA_WIDTH'(take_bits(DATA_WIDTH));
      b        = DATA_WIDTH'(take_bits(DATA_WIDTH));
      do_read  = 1'(take_bits(1));
      do_write = (take_bits(4) == 32'd0);
      pick     = 1'(take_bits(1));
      if (do_write && pick) begin
        address = CFG_ADDR_CLEAR;
        wdata   = DATA_WIDTH'(take_bits(2));
      end else if (do_write) begin
        // Four bits, so zero and eight to fifteen also show up
        address = CFG_ADDR_LATENCY;
        wdata   = DATA_WIDTH'(take_bits(4));
      end else begin
        address = pick ? CFG_ADDR_ERRORS : CFG_ADDR_LATENCY;
        wdata   = '0;
      end
      drive_cycle(do_issue, op, a, b, do_read, do_write, address, wdata);
    end
  endtask

  // Read until the buffer is empty
  task automatic drain_buffer(input int limit);
    int waited;
    waited = 0;
    while (!empty && waited < limit) begin
      drive_cycle(1'b0, OP_ADD, '0, '0, 1'b1, 1'b0, CFG_ADDR_ERRORS, '0);
      waited++;
    end
    if (!empty) begin
      $display("Timeout at %0t: buffer still not empty after %0d cycles", $time, limit);
      timeouts++;
    end
    idle_cycle(CFG_ADDR_ERRORS);
    idle_cycle(CFG_ADDR_LATENCY);
  endtask

  task automatic finish_run;
    int assert_failures;
    int total;
    assert_failures = completion_unit_inst.reorder_buffer_inst.tb_props_inst.failures;
    total           = check_errors + assert_failures + timeouts;
    $display("Run complete: %0d check errors, %0d assertion failures, %0d timeouts",
             check_errors, assert_failures, timeouts);
    if (total == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  initial begin
    lfsr        = 32'h3025e14d;
    timeouts    = 0;
    resetn      = 1'b0;
    issue       = 1'b0;
    issue_op    = OP_ADD;
    issue_a     = '0;
    issue_b     = '0;
    read        = 1'b0;
    cfg_write   = 1'b0;
    cfg_address = CFG_ADDR_LATENCY;
    cfg_wdata   = '0;

    // Reset for two cycles
    repeat (2) @(posedge clock);
    resetn <= 1'b1;
    idle_cycle(CFG_ADDR_LATENCY);
    idle_cycle(CFG_ADDR_ERRORS);

    // Random mix, then empty out
    run_random_mix(600);
    drain_buffer(300);

    // Slow multiply ahead of younger fast work
    write_cycle(CFG_ADDR_LATENCY, 16'd7);
    issue_cycle(OP_MUL);
    issue_cycle(OP_ADD);
    issue_cycle(OP_SUB);
    issue_cycle(OP_XOR);
    issue_cycle(OP_MUL);
    issue_cycle(OP_ADD);
    drain_buffer(100);

    // Fill with reading stopped, four issues bounce
    write_cycle(CFG_ADDR_CLEAR, make_clear_word(1'b1, 1'b1));
    repeat (ROB_DEPTH + 4) issue_cycle(OP_ADD);
    idle_cycle(CFG_ADDR_ERRORS);
    idle_cycle(CFG_ADDR_ERRORS);
    drain_buffer(100);

    // Reads on an empty buffer, then clear the read counter only
    repeat (3) drive_cycle(1'b0, OP_ADD, '0, '0, 1'b1, 1'b0, CFG_ADDR_ERRORS, '0);
    write_cycle(CFG_ADDR_CLEAR, make_clear_word(1'b0, 1'b1));
    idle_cycle(CFG_ADDR_ERRORS);
    idle_cycle(CFG_ADDR_ERRORS);

    // Illegal latencies dropped, legal one kept
    write_cycle(CFG_ADDR_LATENCY, 16'd9);
    write_cycle(CFG_ADDR_LATENCY, 16'd0);
    write_cycle(CFG_ADDR_LATENCY, 16'h0105);
    idle_cycle(CFG_ADDR_LATENCY);
    write_cycle(CFG_ADDR_LATENCY, 16'd5);
    idle_cycle(CFG_ADDR_LATENCY);
    idle_cycle(CFG_ADDR_LATENCY);

    finish_run;
  end

endmodule

//--- vlog.f
logic/rob_pkg.sv
logic/op_pkg.sv
logic/reorder_buffer.sv
logic/exec_lanes.sv
logic/unit_config.sv
logic/completion_unit.sv
test/tb_props.sv
test/tb_checker.sv
test/tb_top.sv

//--- Makefile
# Verilator build and run of the completion unit testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
